/* verilog/vec_pkg.sv */
////////////////////////////////////////
// Vector unit shared definitions
// Element and register sizes, opcodes and instruction fields
////////////////////////////////////////

package vec_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Bits per vector element
  localparam int unsigned ElemWidth = 32;
  // Architectural vector registers
  localparam int unsigned NrVRegs = 8;
  // Element slots per register in each lane, power of two
  localparam int unsigned MaxElemsPerLane = 4;
  // Upper bound for the lane count
  localparam int unsigned MaxNrLanes = 8;

  typedef logic [ElemWidth-1:0] elem_t;
  typedef logic [2:0]           vreg_idx_t;
  // Wide enough for MaxNrLanes * MaxElemsPerLane
  typedef logic [5:0]           vl_t;

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////

  // Codes 10 to 15 are illegal
  typedef enum logic [3:0] {
    OP_SETVL   = 4'd0,
    OP_VADD    = 4'd1,
    OP_VSUB    = 4'd2,
    OP_VAND    = 4'd3,
    OP_VOR     = 4'd4,
    OP_VXOR    = 4'd5,
    OP_VADDX   = 4'd6,
    OP_VMVVX   = 4'd7,
    OP_VMVXS   = 4'd8,
    OP_VREDSUM = 4'd9
  } vec_op_e;

  ////////////////////////////////////////
  // Instruction fields
  ////////////////////////////////////////

  // Bits not covered below are ignored
  localparam int unsigned OpcodeLsb = 0;
  localparam int unsigned OpcodeMsb = 3;
  localparam int unsigned VdLsb     = 4;
  localparam int unsigned VdMsb     = 6;
  localparam int unsigned Vs1Lsb    = 7;
  localparam int unsigned Vs1Msb    = 9;
  localparam int unsigned Vs2Lsb    = 10;
  localparam int unsigned Vs2Msb    = 12;

endpackage

/* verilog/vec_dispatcher.sv */
////////////////////////////////////////
// Vector dispatcher
// Decodes host instructions, keeps vl, issues vector work
// and returns the host response
////////////////////////////////////////

`timescale 1ns/1ps

module vec_dispatcher #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                clk_i,
  input  logic                reset_i,
  // Host side
  input  logic                req_valid_i,
  input  logic [31:0]         insn_i,
  input  vec_pkg::elem_t      scalar_i,
  output logic                busy_o,
  output logic                resp_valid_o,
  output vec_pkg::elem_t      resp_result_o,
  output logic                resp_error_o,
  // Sequencer side
  output logic                issue_o,
  output vec_pkg::vec_op_e    op_o,
  output vec_pkg::vreg_idx_t  vd_o,
  output vec_pkg::vreg_idx_t  vs1_o,
  output vec_pkg::vreg_idx_t  vs2_o,
  output vec_pkg::elem_t      scalar_o,
  output vec_pkg::vl_t        vl_o,
  input  logic                seq_done_i,
  input  vec_pkg::elem_t      seq_result_i
);

  localparam int unsigned VLMAX = NrLanes * vec_pkg::MaxElemsPerLane;

  typedef enum logic {
    IDLE,
    WAIT
  } disp_state_e;

  disp_state_e  state_q;
  vec_pkg::vl_t vl_q;
  vec_pkg::vl_t vl_next;
  logic [3:0]   opcode;
  logic         insn_legal;
  logic         is_setvl;
  logic         accept;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  assign opcode     = insn_i[vec_pkg::OpcodeMsb:vec_pkg::OpcodeLsb];
  assign insn_legal = opcode <= 4'(vec_pkg::OP_VREDSUM);
  assign is_setvl   = opcode == 4'(vec_pkg::OP_SETVL);
  assign accept     = req_valid_i && (state_q == IDLE);

  // New vl saturates at VLMAX
  assign vl_next = (scalar_i > vec_pkg::elem_t'(VLMAX)) ? vec_pkg::vl_t'(VLMAX)
                                                       : scalar_i[$bits(vec_pkg::vl_t)-1:0];

  assign busy_o = state_q == WAIT;
  assign vl_o   = vl_q;

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q      <= IDLE;
      vl_q         <= '0;
      issue_o      <= 1'b0;
      resp_valid_o <= 1'b0;
    end else begin
      issue_o      <= 1'b0;
      resp_valid_o <= 1'b0;
      case (state_q)
        IDLE: begin
          if (req_valid_i) begin
            // SETVL and illegal codes finish here
            if (is_setvl || !insn_legal) begin
              resp_valid_o <= 1'b1;
            end else begin
              issue_o <= 1'b1;
              state_q <= WAIT;
            end
            if (is_setvl) begin
              vl_q <= vl_next;
            end
          end
        end
        WAIT: begin
          if (seq_done_i) begin
            resp_valid_o <= 1'b1;
            state_q      <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Issued instruction and response payload
  always_ff @(posedge clk_i) begin
    if (accept && insn_legal) begin
      op_o     <= vec_pkg::vec_op_e'(opcode);
      vd_o     <= insn_i[vec_pkg::VdMsb:vec_pkg::VdLsb];
      vs1_o    <= insn_i[vec_pkg::Vs1Msb:vec_pkg::Vs1Lsb];
      vs2_o    <= insn_i[vec_pkg::Vs2Msb:vec_pkg::Vs2Lsb];
      scalar_o <= scalar_i;
    end
    if (accept && !insn_legal) begin
      resp_result_o <= '0;
      resp_error_o  <= 1'b1;
    end else if (accept && is_setvl) begin
      resp_result_o <= vec_pkg::elem_t'(vl_next);
      resp_error_o  <= 1'b0;
    end else if (busy_o && seq_done_i) begin
      resp_result_o <= seq_result_i;
      resp_error_o  <= 1'b0;
    end
  end

  // Host must wait for busy to drop before the next request
  assert property (@(posedge clk_i) disable iff (reset_i) busy_o |-> !req_valid_i)
    else $error("request while busy");

endmodule

/* verilog/vec_sequencer.sv */
////////////////////////////////////////
// Vector sequencer
// Broadcasts one instruction to all lanes and merges results
////////////////////////////////////////

`timescale 1ns/1ps

module vec_sequencer #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                              clk_i,
  input  logic                              reset_i,
  // Dispatcher side
  input  logic                              issue_i,
  input  vec_pkg::vec_op_e                  op_i,
  input  vec_pkg::vreg_idx_t                vd_i,
  input  vec_pkg::vreg_idx_t                vs1_i,
  input  vec_pkg::vreg_idx_t                vs2_i,
  input  vec_pkg::elem_t                    scalar_i,
  input  vec_pkg::vl_t                      vl_i,
  output logic                              done_o,
  output vec_pkg::elem_t                    result_o,
  // Lane side, held stable until done
  output logic                              start_o,
  output vec_pkg::vec_op_e                  op_o,
  output vec_pkg::vreg_idx_t                vd_o,
  output vec_pkg::vreg_idx_t                vs1_o,
  output vec_pkg::vreg_idx_t                vs2_o,
  output vec_pkg::elem_t                    scalar_o,
  output vec_pkg::vl_t                      vl_o,
  input  logic [NrLanes-1:0]                lane_done_i,
  input  vec_pkg::elem_t [NrLanes-1:0]      lane_partial_i
);

  localparam int unsigned VLMAX    = NrLanes * vec_pkg::MaxElemsPerLane;
  localparam int unsigned LaneSelW = (NrLanes > 1) ? $clog2(NrLanes) : 1;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    RESP
  } seq_state_e;

  seq_state_e          state_q;
  logic [NrLanes-1:0]  seen_q;
  logic                all_done;
  logic [LaneSelW-1:0] lane_sel;
  vec_pkg::elem_t      red_sum;
  vec_pkg::elem_t      result_d;

  assign all_done = &(seen_q | lane_done_i);
  assign done_o   = state_q == RESP;
  // Element k sits in lane k mod NrLanes
  assign lane_sel = LaneSelW'((scalar_o % VLMAX) % NrLanes);

  ////////////////////////////////////////
  // Result merge
  ////////////////////////////////////////

  always_comb begin
    red_sum = scalar_o;
    for (int i = 0; i < NrLanes; i++) begin
      red_sum = red_sum + lane_partial_i[i];
    end
    case (op_o)
      vec_pkg::OP_VREDSUM: result_d = red_sum;
      vec_pkg::OP_VMVXS:   result_d = lane_partial_i[lane_sel];
      default:             result_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      start_o <= 1'b0;
      seen_q  <= '0;
    end else begin
      start_o <= 1'b0;
      case (state_q)
        IDLE: begin
          if (issue_i) begin
            start_o <= 1'b1;
            seen_q  <= '0;
            state_q <= RUN;
          end
        end
        RUN: begin
          seen_q <= seen_q | lane_done_i;
          if (all_done) begin
            state_q <= RESP;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && issue_i) begin
      op_o     <= op_i;
      vd_o     <= vd_i;
      vs1_o    <= vs1_i;
      vs2_o    <= vs2_i;
      scalar_o <= scalar_i;
      vl_o     <= vl_i;
    end
    if ((state_q == RUN) && all_done) begin
      result_o <= result_d;
    end
  end

  // Lanes only report while an instruction is running
  assert property (@(posedge clk_i) disable iff (reset_i) |lane_done_i |-> state_q == RUN)
    else $error("lane done outside RUN");

  if (NrLanes == 0 || NrLanes != 2 ** $clog2(NrLanes))
    $error("NrLanes must be a power of two");
  if (NrLanes > vec_pkg::MaxNrLanes)
    $error("NrLanes exceeds MaxNrLanes");

endmodule

/* verilog/vec_lane.sv */
////////////////////////////////////////
// Vector lane
// Register file slice, element loop and integer ALU
////////////////////////////////////////

`timescale 1ns/1ps

module vec_lane #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned LaneId  = 0
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               start_i,
  input  vec_pkg::vec_op_e   op_i,
  input  vec_pkg::vreg_idx_t vd_i,
  input  vec_pkg::vreg_idx_t vs1_i,
  input  vec_pkg::vreg_idx_t vs2_i,
  input  vec_pkg::elem_t     scalar_i,
  input  vec_pkg::vl_t       vl_i,
  output logic               done_o,
  output vec_pkg::elem_t     partial_o
);

  localparam int unsigned VLMAX = NrLanes * vec_pkg::MaxElemsPerLane;
  localparam int unsigned SlotW = $clog2(vec_pkg::MaxElemsPerLane);
  localparam int unsigned CntW  = SlotW + 1;

  vec_pkg::elem_t vrf_q [vec_pkg::NrVRegs][vec_pkg::MaxElemsPerLane];

  logic             running_q;
  logic [SlotW-1:0] slot_q;
  logic [SlotW-1:0] mv_slot;
  logic [CntW-1:0]  elem_cnt;
  logic             active;
  logic             last_slot;
  logic             elem_op;
  logic             wr_en;
  vec_pkg::elem_t   src_a;
  vec_pkg::elem_t   src_b;
  vec_pkg::elem_t   alu_res;

  ////////////////////////////////////////
  // Element bookkeeping
  ////////////////////////////////////////

  // Elements LaneId, LaneId+NrLanes, ... below vl belong here
  always_comb begin
    if (vl_i > vec_pkg::vl_t'(LaneId)) begin
      elem_cnt = CntW'((vl_i - vec_pkg::vl_t'(LaneId) - 1'b1) / NrLanes + 1);
    end else begin
      elem_cnt = '0;
    end
  end

  assign active    = CntW'(slot_q) < elem_cnt;
  assign last_slot = (CntW'(slot_q) + 1'b1) >= elem_cnt;
  // Slot of element k for a scalar read, k wraps at VLMAX
  assign mv_slot   = SlotW'((scalar_i % VLMAX) / NrLanes);

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  always_comb begin
    src_a   = vrf_q[vs2_i][slot_q];
    src_b   = vrf_q[vs1_i][slot_q];
    alu_res = '0;
    elem_op = 1'b1;
    case (op_i)
      vec_pkg::OP_VADD:  alu_res = src_a + src_b;
      vec_pkg::OP_VSUB:  alu_res = src_a - src_b;
      vec_pkg::OP_VAND:  alu_res = src_a & src_b;
      vec_pkg::OP_VOR:   alu_res = src_a | src_b;
      vec_pkg::OP_VXOR:  alu_res = src_a ^ src_b;
      vec_pkg::OP_VADDX: alu_res = src_a + scalar_i;
      vec_pkg::OP_VMVVX: alu_res = scalar_i;
      default:           elem_op = 1'b0;
    endcase
  end

  // Tail elements at or above vl are never written
  assign wr_en = elem_op && running_q && active;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      running_q <= 1'b0;
      done_o    <= 1'b0;
      slot_q    <= '0;
      for (int r = 0; r < vec_pkg::NrVRegs; r++) begin
        for (int s = 0; s < vec_pkg::MaxElemsPerLane; s++) begin
          vrf_q[r][s] <= '0;
        end
      end
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        running_q <= 1'b1;
        slot_q    <= '0;
      end else if (running_q) begin
        slot_q <= slot_q + 1'b1;
        // At least one cycle even with no active elements
        if (last_slot) begin
          running_q <= 1'b0;
          done_o    <= 1'b1;
        end
      end
      if (wr_en) begin
        vrf_q[vd_i][slot_q] <= alu_res;
      end
    end
  end

  // Partial sum, or the element picked for a scalar read
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      partial_o <= (op_i == vec_pkg::OP_VMVXS) ? vrf_q[vs2_i][mv_slot] : '0;
    end else if (running_q && active && (op_i == vec_pkg::OP_VREDSUM)) begin
      partial_o <= partial_o + src_a;
    end
  end

  // Sequencer never restarts a lane mid-instruction
  assert property (@(posedge clk_i) disable iff (reset_i) start_i |-> !running_q)
    else $error("lane %0d started while running", LaneId);

endmodule

/* verilog/vec_top.sv */
////////////////////////////////////////
// Vector coprocessor top level
// Dispatcher, sequencer and NrLanes lanes
////////////////////////////////////////

`timescale 1ns/1ps

module vec_top #(
  parameter int unsigned NrLanes = 4
) (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           req_valid_i,
  input  logic [31:0]    insn_i,
  input  vec_pkg::elem_t scalar_i,
  output logic           busy_o,
  output logic           resp_valid_o,
  output vec_pkg::elem_t resp_result_o,
  output logic           resp_error_o
);

  // Dispatcher to sequencer
  logic                         disp_issue;
  vec_pkg::vec_op_e             disp_op;
  vec_pkg::vreg_idx_t           disp_vd;
  vec_pkg::vreg_idx_t           disp_vs1;
  vec_pkg::vreg_idx_t           disp_vs2;
  vec_pkg::elem_t               disp_scalar;
  vec_pkg::vl_t                 disp_vl;
  logic                         seq_done;
  vec_pkg::elem_t               seq_result;

  // Sequencer to lanes
  logic                         lane_start;
  vec_pkg::vec_op_e             lane_op;
  vec_pkg::vreg_idx_t           lane_vd;
  vec_pkg::vreg_idx_t           lane_vs1;
  vec_pkg::vreg_idx_t           lane_vs2;
  vec_pkg::elem_t               lane_scalar;
  vec_pkg::vl_t                 lane_vl;
  logic [NrLanes-1:0]           lane_done;
  vec_pkg::elem_t [NrLanes-1:0] lane_partial;

  vec_dispatcher #(
    .NrLanes(NrLanes)
  ) u_dispatcher (
    .clk_i        (clk_i        ),
    .reset_i      (reset_i      ),
    .req_valid_i  (req_valid_i  ),
    .insn_i       (insn_i       ),
    .scalar_i     (scalar_i     ),
    .busy_o       (busy_o       ),
    .resp_valid_o (resp_valid_o ),
    .resp_result_o(resp_result_o),
    .resp_error_o (resp_error_o ),
    .issue_o      (disp_issue   ),
    .op_o         (disp_op      ),
    .vd_o         (disp_vd      ),
    .vs1_o        (disp_vs1     ),
    .vs2_o        (disp_vs2     ),
    .scalar_o     (disp_scalar  ),
    .vl_o         (disp_vl      ),
    .seq_done_i   (seq_done     ),
    .seq_result_i (seq_result   )
  );

  vec_sequencer #(
    .NrLanes(NrLanes)
  ) u_sequencer (
    .clk_i         (clk_i       ),
    .reset_i       (reset_i     ),
    .issue_i       (disp_issue  ),
    .op_i          (disp_op     ),
    .vd_i          (disp_vd     ),
    .vs1_i         (disp_vs1    ),
    .vs2_i         (disp_vs2    ),
    .scalar_i      (disp_scalar ),
    .vl_i          (disp_vl     ),
    .done_o        (seq_done    ),
    .result_o      (seq_result  ),
    .start_o       (lane_start  ),
    .op_o          (lane_op     ),
    .vd_o          (lane_vd     ),
    .vs1_o         (lane_vs1    ),
    .vs2_o         (lane_vs2    ),
    .scalar_o      (lane_scalar ),
    .vl_o          (lane_vl     ),
    .lane_done_i   (lane_done   ),
    .lane_partial_i(lane_partial)
  );

  for (genvar g = 0; g < NrLanes; g++) begin : gen_lanes
    vec_lane #(
      .NrLanes(NrLanes),
      .LaneId (g      )
    ) u_lane (
      .clk_i    (clk_i          ),
      .reset_i  (reset_i        ),
      .start_i  (lane_start     ),
      .op_i     (lane_op        ),
      .vd_i     (lane_vd        ),
      .vs1_i    (lane_vs1       ),
      .vs2_i    (lane_vs2       ),
      .scalar_i (lane_scalar    ),
      .vl_i     (lane_vl        ),
      .done_o   (lane_done[g]   ),
      .partial_o(lane_partial[g])
    );
  end

endmodule

/* testbench/tb_vec_top.sv */
////////////////////////////////////////
// Vector coprocessor testbench
// Random instructions checked against a register file model
////////////////////////////////////////

`timescale 1ns/1ps

module tb_vec_top;

  localparam int unsigned NrLanes     = 4;
  localparam int unsigned VLMAX       = NrLanes * vec_pkg::MaxElemsPerLane;
  localparam int unsigned ClkPeriod   = 20;
  localparam int unsigned ResetCycles = 4;
  localparam int unsigned NumRandOps  = 12;
  localparam int unsigned NumRedSums  = 6;
  localparam int unsigned NumIllegal  = 6;
  // Instructions issued over all tests
  localparam int unsigned NumInsns = 2 + (1 + VLMAX) + 2 * vec_pkg::NrVRegs
                                   + NumRandOps * (2 + VLMAX) + 2 * NumRedSums
                                   + NumIllegal * (1 + VLMAX);
  localparam int unsigned WatchdogCycles = 2 * NumInsns * (VLMAX + 10);

  logic           clk_i;
  logic           reset_i;
  logic           req_valid_i;
  logic [31:0]    insn_i;
  vec_pkg::elem_t scalar_i;
  logic           busy_o;
  logic           resp_valid_o;
  vec_pkg::elem_t resp_result_o;
  logic           resp_error_o;

  integer         seed;
  logic           resp_pending;
  vec_pkg::elem_t exp_result;
  logic           exp_error;
  string          insn_desc;

  // Model state
  vec_pkg::elem_t vrf_ref [vec_pkg::NrVRegs][VLMAX];
  int unsigned    vl_ref;

  vec_top #(
    .NrLanes(NrLanes)
  ) u_dut (
    .clk_i        (clk_i        ),
    .reset_i      (reset_i      ),
    .req_valid_i  (req_valid_i  ),
    .insn_i       (insn_i       ),
    .scalar_i     (scalar_i     ),
    .busy_o       (busy_o       ),
    .resp_valid_o (resp_valid_o ),
    .resp_result_o(resp_result_o),
    .resp_error_o (resp_error_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #((WatchdogCycles + ResetCycles) * ClkPeriod);
    $display("Watchdog expired: the DUT stopped responding before the tests finished");
    $display("TESTBENCH FAILED");
    $fatal(1, "watchdog timeout");
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_result(input vec_pkg::elem_t got, input vec_pkg::elem_t exp);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %0t ns: %s gave result 0x%08h, expected 0x%08h",
                         $time, insn_desc, got, exp));
    end
  endtask

  task automatic check_error(input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %0t ns: %s gave error %b, expected %b",
                         $time, insn_desc, got, exp));
    end
  endtask

  // Responses are sampled mid-cycle, away from the clock edge
  always @(negedge clk_i) begin
    if (resp_valid_o === 1'b1) begin
      if (!resp_pending) begin
        stop_run("A response pulse arrived with no instruction waiting for it");
      end else begin
        check_result(resp_result_o, exp_result);
        check_error(resp_error_o, exp_error);
        resp_pending = 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic void ref_exec(input logic [31:0] insn, input vec_pkg::elem_t scalar,
                                   output vec_pkg::elem_t result, output logic error);
    logic [3:0]     op;
    int unsigned    vd;
    int unsigned    vs1;
    int unsigned    vs2;
    int unsigned    i;
    vec_pkg::elem_t a;
    vec_pkg::elem_t b;
    op     = insn[3:0];
    vd     = insn[6:4];
    vs1    = insn[9:7];
    vs2    = insn[12:10];
    result = '0;
    error  = 1'b0;
    if (op > 4'd9) begin
      error = 1'b1;
    end else if (op == 4'd0) begin
      vl_ref = (scalar > VLMAX) ? VLMAX : scalar;
      result = vl_ref;
    end else if (op == 4'd8) begin
      result = vrf_ref[vs2][scalar % VLMAX];
    end else if (op == 4'd9) begin
      result = scalar;
      for (i = 0; i < vl_ref; i++) begin
        result = result + vrf_ref[vs2][i];
      end
    end else begin
      // Tail at and above vl stays as it is
      for (i = 0; i < vl_ref; i++) begin
        a = vrf_ref[vs2][i];
        b = vrf_ref[vs1][i];
        case (op)
          4'd1:    vrf_ref[vd][i] = a + b;
          4'd2:    vrf_ref[vd][i] = a - b;
          4'd3:    vrf_ref[vd][i] = a & b;
          4'd4:    vrf_ref[vd][i] = a | b;
          4'd5:    vrf_ref[vd][i] = a ^ b;
          4'd6:    vrf_ref[vd][i] = a + scalar;
          default: vrf_ref[vd][i] = scalar;
        endcase
      end
    end
  endfunction

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  function automatic vec_pkg::vreg_idx_t rand_vreg();
    return vec_pkg::vreg_idx_t'($random(seed));
  endfunction

  // Unused upper bits get random junk
  function automatic logic [31:0] make_insn(input logic [3:0] op, input vec_pkg::vreg_idx_t vd,
                                            input vec_pkg::vreg_idx_t vs1,
                                            input vec_pkg::vreg_idx_t vs2);
    logic [31:0] junk;
    junk = $random(seed);
    return {junk[31:13], vs2, vs1, vd, op};
  endfunction

  task automatic run_insn(input logic [31:0] insn, input vec_pkg::elem_t scalar);
    @(posedge clk_i);
    #2;
    if (busy_o !== 1'b0 || resp_valid_o !== 1'b0) begin
      stop_run("busy_o or resp_valid_o still high when the next request was due");
    end
    insn_desc = $sformatf("opcode %0d (insn 0x%08h, scalar 0x%08h)", insn[3:0], insn, scalar);
    ref_exec(insn, scalar, exp_result, exp_error);
    resp_pending = 1'b1;
    req_valid_i  = 1'b1;
    insn_i       = insn;
    scalar_i     = scalar;
    @(posedge clk_i);
    #2;
    req_valid_i = 1'b0;
    @(negedge clk_i);
    while (resp_valid_o !== 1'b1) begin
      if (busy_o !== 1'b1) begin
        stop_run($sformatf("busy_o went low before the response of %s", insn_desc));
      end
      @(negedge clk_i);
    end
    if (busy_o !== 1'b0) begin
      stop_run($sformatf("busy_o stayed high in the response cycle of %s", insn_desc));
    end
  endtask

  // Reads every element of one register, index wraps at VLMAX
  task automatic read_vreg(input vec_pkg::vreg_idx_t vs2);
    int unsigned k;
    for (k = 0; k < VLMAX; k++) begin
      run_insn(make_insn(vec_pkg::OP_VMVXS, rand_vreg(), rand_vreg(), vs2),
               vec_pkg::elem_t'(k + VLMAX * ($unsigned($random(seed)) % 4)));
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    int unsigned        n;
    logic [3:0]         op;
    vec_pkg::vreg_idx_t vd;
    seed         = 32'h8a70;
    resp_pending = 1'b0;
    exp_result   = '0;
    exp_error    = 1'b0;
    insn_desc    = "";
    reset_i      = 1'b1;
    req_valid_i  = 1'b0;
    insn_i       = '0;
    scalar_i     = '0;
    vl_ref       = 0;
    foreach (vrf_ref[r, e]) vrf_ref[r][e] = '0;
    repeat (ResetCycles) @(posedge clk_i);
    #2;
    reset_i = 1'b0;

    // Saturating and plain vector length
    run_insn(make_insn(vec_pkg::OP_SETVL, 3'd0, 3'd0, 3'd0), 32'd100);
    run_insn(make_insn(vec_pkg::OP_SETVL, 3'd0, 3'd0, 3'd0), 32'd5);

    // Broadcast with vl 5, tail must read back as zero
    run_insn(make_insn(vec_pkg::OP_VMVVX, 3'd2, rand_vreg(), rand_vreg()), $random(seed));
    read_vreg(3'd2);

    // Random register contents
    for (n = 0; n < vec_pkg::NrVRegs; n++) begin
      run_insn(make_insn(vec_pkg::OP_SETVL, 3'd0, 3'd0, 3'd0),
               $unsigned($random(seed)) % (VLMAX + 1));
      run_insn(make_insn(vec_pkg::OP_VMVVX, vec_pkg::vreg_idx_t'(n), rand_vreg(), rand_vreg()),
               $random(seed));
    end

    // Element-wise ALU ops, VADD through VADDX
    for (n = 0; n < NumRandOps; n++) begin
      run_insn(make_insn(vec_pkg::OP_SETVL, 3'd0, 3'd0, 3'd0),
               $unsigned($random(seed)) % (VLMAX + 5));
      op = 4'(1 + $unsigned($random(seed)) % 6);
      vd = rand_vreg();
      run_insn(make_insn(op, vd, rand_vreg(), rand_vreg()), $random(seed));
      read_vreg(vd);
    end

    // Reductions, the first one with vl 0
    for (n = 0; n < NumRedSums; n++) begin
      run_insn(make_insn(vec_pkg::OP_SETVL, 3'd0, 3'd0, 3'd0),
               (n == 0) ? 32'd0 : $unsigned($random(seed)) % (VLMAX + 1));
      run_insn(make_insn(vec_pkg::OP_VREDSUM, rand_vreg(), rand_vreg(), rand_vreg()),
               $random(seed));
    end

    // Illegal codes 10 to 15
    for (n = 0; n < NumIllegal; n++) begin
      vd = rand_vreg();
      run_insn(make_insn(4'(10 + n), vd, rand_vreg(), rand_vreg()), $random(seed));
      read_vreg(vd);
    end

    @(negedge clk_i);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* files.f */
verilog/vec_pkg.sv
verilog/vec_dispatcher.sv
verilog/vec_sequencer.sv
verilog/vec_lane.sv
verilog/vec_top.sv
testbench/tb_vec_top.sv
